// ==== core_pkg.sv ====
package core_pkg;

    //////////////////////////////////////////////////
    // Datapath widths
    //////////////////////////////////////////////////

    parameter int xlen = 32;  // Data and address width.

    typedef logic [xlen-1:0] addr_t;

    //////////////////////////////////////////////////
    // Program counter constants
    //////////////////////////////////////////////////

    // Byte distance between two sequential instructions.
    parameter addr_t pc_step = addr_t'(4);

    // Boot address of the core.
    parameter addr_t reset_pc_default = 32'h8000_0000;

endpackage

// ==== fetch_pkg.sv ====
package fetch_pkg;

    import core_pkg::*;

    //////////////////////////////////////////////////
    // State encodings
    //////////////////////////////////////////////////

    typedef enum logic [1:0] {
        BUS_IDLE = 2'd0,  // No read outstanding.
        BUS_WAIT = 2'd1,  // Address taken, data pending.
        BUS_DONE = 2'd2   // Data returned.
    } bus_state_e;

    typedef enum logic [1:0] {
        MD_IDLE       = 2'd0,
        MD_EXEC       = 2'd1,  // Multiplier or divider busy.
        MD_WAIT_FETCH = 2'd2,  // Result ready, next fetch pending.
        MD_RETIRE     = 2'd3
    } md_state_e;

    // Op class from decode. Taken branches and jal both map to OP_REDIRECT.
    typedef enum logic [2:0] {
        OP_NONE     = 3'd0,
        OP_MUL      = 3'd1,
        OP_DIV      = 3'd2,
        OP_JALR     = 3'd3,
        OP_REDIRECT = 3'd4
    } id_op_e;

    //////////////////////////////////////////////////
    // Interface bundles
    //////////////////////////////////////////////////

    typedef struct packed {
        id_op_e op;
        logic   mem_stall;  // Decode held by a load or store.
        addr_t  next_pc;
    } id_info_t;

    typedef struct packed {
        logic mul_done;
        logic div_done;
    } exec_done_t;

    typedef struct packed {
        logic ar_hs;   // Read address accepted.
        logic r_done;  // Read data returned.
    } bus_evt_t;

endpackage

// ==== fetch_bus_track.sv ====
`timescale 1ns/10ps

module fetch_bus_track (
    input  logic                clk,
    input  logic                rst_n,
    input  fetch_pkg::bus_evt_t bus,
    output logic                if_valid
);

    import fetch_pkg::*;

    bus_state_e state;
    bus_state_e state_nxt;

    //////////////////////////////////////////////////
    // Read tracking FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= BUS_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            BUS_IDLE: begin
                if (bus.ar_hs) begin
                    state_nxt = BUS_WAIT;
                end
            end
            BUS_WAIT: begin
                if (bus.r_done) begin
                    state_nxt = BUS_DONE;
                end
            end
            BUS_DONE: begin
                state_nxt = BUS_IDLE;  // One cycle only.
            end
            default: begin
                state_nxt = BUS_IDLE;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // Fetch request flag
    //////////////////////////////////////////////////

    // A new read may start only after a cycle with nothing in flight.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            if_valid <= 1'b0;
        end else begin
            if_valid <= (state == BUS_IDLE);
        end
    end

endmodule

// ==== muldiv_track.sv ====
`timescale 1ns/10ps

module muldiv_track (
    input  logic                  clk,
    input  logic                  rst_n,
    input  fetch_pkg::id_op_e     op,
    input  fetch_pkg::exec_done_t exec,
    input  logic                  r_done,
    output fetch_pkg::md_state_e  md_phase
);

    import fetch_pkg::*;

    md_state_e md_nxt;
    logic      md_issue;
    logic      md_finish;

    assign md_issue  = (op == OP_MUL) || (op == OP_DIV);
    assign md_finish = exec.mul_done || exec.div_done;

    //////////////////////////////////////////////////
    // Multiply/divide phase FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            md_phase <= MD_IDLE;
        end else begin
            md_phase <= md_nxt;
        end
    end

    always_comb begin
        md_nxt = md_phase;
        case (md_phase)
            MD_IDLE: begin
                if (md_issue) begin
                    md_nxt = MD_EXEC;
                end
            end
            MD_EXEC: begin
                if (md_finish) begin
                    md_nxt = MD_WAIT_FETCH;
                end
            end
            MD_WAIT_FETCH: begin
                // The refetch after the result must land first.
                if (r_done) begin
                    md_nxt = MD_RETIRE;
                end
            end
            MD_RETIRE: begin
                md_nxt = MD_IDLE;  // Single retire cycle.
            end
            default: begin
                md_nxt = MD_IDLE;
            end
        endcase
    end

endmodule

// ==== pc_update.sv ====
`timescale 1ns/10ps

module pc_update #(
    parameter core_pkg::addr_t RESET_PC = core_pkg::reset_pc_default
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  fetch_pkg::id_info_t         id,
    input  fetch_pkg::exec_done_t       exec,
    input  logic                        r_done,
    input  fetch_pkg::md_state_e        md_phase,
    output logic [core_pkg::xlen-1:0]   curr_pc,
    output logic                        fetch_en
);

    import core_pkg::*;
    import fetch_pkg::*;

    typedef enum logic [1:0] {
        PC_HOLD = 2'd0,
        PC_STEP = 2'd1,
        PC_LOAD = 2'd2
    } pc_sel_e;

    pc_sel_e pc_sel;
    logic    jalr_d;
    logic    md_busy;
    addr_t   pc_nxt;

    // Normal fetch steps are owned by the tracker while an op is in flight.
    assign md_busy = (md_phase == MD_EXEC) || (md_phase == MD_WAIT_FETCH);

    //////////////////////////////////////////////////
    // Next PC selection
    //////////////////////////////////////////////////

    always_comb begin
        if (id.op == OP_MUL) begin
            pc_sel = exec.mul_done ? PC_STEP : PC_HOLD;
        end else if (id.op == OP_DIV) begin
            pc_sel = exec.div_done ? PC_STEP : PC_HOLD;
        end else if (id.mem_stall) begin
            pc_sel = PC_HOLD;
        end else if (id.op == OP_JALR) begin
            pc_sel = PC_HOLD;  // Target not ready yet.
        end else if (jalr_d) begin
            pc_sel = PC_LOAD;
        end else if (id.op == OP_REDIRECT) begin
            pc_sel = PC_LOAD;
        end else if ((r_done && !md_busy) || (md_phase == MD_RETIRE)) begin
            pc_sel = PC_STEP;
        end else begin
            pc_sel = PC_HOLD;
        end
    end

    always_comb begin
        case (pc_sel)
            PC_STEP: pc_nxt = curr_pc + pc_step;
            PC_LOAD: pc_nxt = id.next_pc;
            default: pc_nxt = curr_pc;
        endcase
    end

    //////////////////////////////////////////////////
    // Registers
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            curr_pc  <= RESET_PC;
            jalr_d   <= 1'b0;
            fetch_en <= 1'b0;
        end else begin
            curr_pc  <= pc_nxt;
            jalr_d   <= (id.op == OP_JALR);  // Load target one cycle later.
            fetch_en <= 1'b1;
        end
    end

endmodule

// ==== fetch_ctrl_top.sv ====
`timescale 1ns/10ps

module fetch_ctrl_top #(
    parameter core_pkg::addr_t RESET_PC = core_pkg::reset_pc_default
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  fetch_pkg::id_info_t         id,
    input  fetch_pkg::exec_done_t       exec,
    input  fetch_pkg::bus_evt_t         bus,
    output logic [core_pkg::xlen-1:0]   curr_pc,
    output logic                        if_valid,
    output logic                        fetch_en
);

    import fetch_pkg::*;

    md_state_e md_phase;

    //////////////////////////////////////////////////
    // Trackers
    //////////////////////////////////////////////////

    fetch_bus_track fetch_bus_track_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .bus      (bus),
        .if_valid (if_valid)
    );

    muldiv_track muldiv_track_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .op       (id.op),
        .exec     (exec),
        .r_done   (bus.r_done),
        .md_phase (md_phase)
    );

    //////////////////////////////////////////////////
    // Program counter
    //////////////////////////////////////////////////

    pc_update #(
        .RESET_PC (RESET_PC)
    ) pc_update_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .id       (id),
        .exec     (exec),
        .r_done   (bus.r_done),
        .md_phase (md_phase),
        .curr_pc  (curr_pc),
        .fetch_en (fetch_en)
    );

endmodule

// ==== fetch_ctrl_chk.sv ====
`timescale 1ns/10ps

module fetch_ctrl_chk (
    input logic                      clk,
    input logic                      rst_n,
    input fetch_pkg::id_info_t       id,
    input fetch_pkg::exec_done_t     exec,
    input fetch_pkg::bus_evt_t       bus,
    input logic [core_pkg::xlen-1:0] curr_pc,
    input logic                      if_valid
);

    import fetch_pkg::*;

    logic md_held;  // Result still pending.
    int   fail_cnt = 0;

    assign md_held = ((id.op == OP_MUL) && !exec.mul_done)
                  || ((id.op == OP_DIV) && !exec.div_done);

    //////////////////////////////////////////////////
    // Fetch bus
    //////////////////////////////////////////////////

    // if_valid high with no handshake just before means the bus was idle.
    a_valid_drops: assert property (@(posedge clk) disable iff (!rst_n)
        (bus.ar_hs && if_valid && !$past(bus.ar_hs)) |-> ##2 !if_valid)
        else begin
            $error("if_valid still high after an accepted read address");
            fail_cnt++;
        end

    //////////////////////////////////////////////////
    // Program counter
    //////////////////////////////////////////////////

    a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        curr_pc[1:0] == 2'b00)
        else begin
            $error("curr_pc is not word aligned");
            fail_cnt++;
        end

    a_md_hold: assert property (@(posedge clk) disable iff (!rst_n)
        md_held |=> $stable(curr_pc))
        else begin
            $error("curr_pc moved while a multiply or divide was pending");
            fail_cnt++;
        end

endmodule

bind fetch_ctrl_top fetch_ctrl_chk fetch_ctrl_chk_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .id       (id),
    .exec     (exec),
    .bus      (bus),
    .curr_pc  (curr_pc),
    .if_valid (if_valid)
);

// ==== fetch_ctrl_tb.sv ====
`timescale 1ns/10ps

module fetch_ctrl_tb;

    import core_pkg::*;
    import fetch_pkg::*;

    localparam addr_t tb_reset_pc = 32'h0000_1000;
    localparam int    run_cycles  = 5000;
    localparam int    md_timeout  = 64;

    logic       clk = 1'b0;
    logic       rst_n;
    id_info_t   id;
    exec_done_t exec;
    bus_evt_t   bus;
    addr_t      curr_pc;
    logic       if_valid;
    logic       fetch_en;

    id_info_t   id_drv;    // Decode values for the next edge.
    exec_done_t exec_drv;

    bus_state_e ref_bus_st;
    md_state_e  ref_md_st;
    addr_t      ref_pc;
    logic       ref_jalr_d;
    logic       ref_if_valid;
    logic       ref_fetch_en;

    logic       rsp_busy;  // Read outstanding on the bus.
    logic       rsp_hold;
    int         rsp_cnt;
    logic       if_valid_seen;

    string      test_name;
    int         cycle_cnt;
    int         n_checks;
    int         err_cnt;
    int         timeout_cnt;
    int         chk_fails;

    always #2 clk = ~clk;

    fetch_ctrl_top #(
        .RESET_PC (tb_reset_pc)
    ) fetch_ctrl_top_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .id       (id),
        .exec     (exec),
        .bus      (bus),
        .curr_pc  (curr_pc),
        .if_valid (if_valid),
        .fetch_en (fetch_en)
    );

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    task automatic advance_model();
        bus_state_e bus_nxt;
        md_state_e  md_nxt;
        logic       md_busy;
        addr_t      pc_nxt;
        bus_nxt = ref_bus_st;
        if (ref_bus_st == BUS_IDLE && bus.ar_hs) begin
            bus_nxt = BUS_WAIT;
        end else if (ref_bus_st == BUS_WAIT && bus.r_done) begin
            bus_nxt = BUS_DONE;
        end else if (ref_bus_st == BUS_DONE) begin
            bus_nxt = BUS_IDLE;
        end
        md_nxt = ref_md_st;
        if (ref_md_st == MD_IDLE && (id.op == OP_MUL || id.op == OP_DIV)) begin
            md_nxt = MD_EXEC;
        end else if (ref_md_st == MD_EXEC && (exec.mul_done || exec.div_done)) begin
            md_nxt = MD_WAIT_FETCH;
        end else if (ref_md_st == MD_WAIT_FETCH && bus.r_done) begin
            md_nxt = MD_RETIRE;
        end else if (ref_md_st == MD_RETIRE) begin
            md_nxt = MD_IDLE;
        end
        md_busy = (ref_md_st == MD_EXEC) || (ref_md_st == MD_WAIT_FETCH);
        pc_nxt  = ref_pc;
        if (id.op == OP_MUL) begin
            if (exec.mul_done) begin
                pc_nxt = ref_pc + 32'd4;
            end
        end else if (id.op == OP_DIV) begin
            if (exec.div_done) begin
                pc_nxt = ref_pc + 32'd4;
            end
        end else if (id.mem_stall || id.op == OP_JALR) begin
            pc_nxt = ref_pc;
        end else if (ref_jalr_d || id.op == OP_REDIRECT) begin
            pc_nxt = id.next_pc;
        end else if ((bus.r_done && !md_busy) || ref_md_st == MD_RETIRE) begin
            pc_nxt = ref_pc + 32'd4;
        end
        ref_if_valid = (ref_bus_st == BUS_IDLE);  // From the old state.
        ref_fetch_en = 1'b1;
        ref_jalr_d   = (id.op == OP_JALR);
        ref_bus_st   = bus_nxt;
        ref_md_st    = md_nxt;
        ref_pc       = pc_nxt;
    endtask

    task automatic check_outputs();
        n_checks++;
        assert (curr_pc === ref_pc) else begin
            $display("Fail %s: curr_pc expected %h, actual %h", test_name, ref_pc, curr_pc);
            err_cnt++;
        end
        assert (if_valid === ref_if_valid) else begin
            $display("Fail %s: if_valid expected %b, actual %b", test_name, ref_if_valid,
                     if_valid);
            err_cnt++;
        end
        assert (fetch_en === ref_fetch_en) else begin
            $display("Fail %s: fetch_en expected %b, actual %b", test_name, ref_fetch_en,
                     fetch_en);
            err_cnt++;
        end
    endtask

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    // Read responder. One read at a time, data after 1 to 4 cycles.
    task automatic respond_bus();
        bus_evt_t nxt;
        nxt = '0;
        if (rsp_busy) begin
            if (rsp_cnt == 0) begin
                nxt.r_done = 1'b1;
                rsp_busy   = 1'b0;
                rsp_hold   = 1'b1;  // if_valid is stale for one cycle.
            end else begin
                rsp_cnt--;
            end
        end else if (rsp_hold) begin
            rsp_hold = 1'b0;
        end else if (if_valid_seen && $urandom_range(0, 3) != 0) begin
            nxt.ar_hs = 1'b1;
            rsp_busy  = 1'b1;
            rsp_cnt   = $urandom_range(0, 3);
        end
        bus <= nxt;
    endtask

    task automatic step_cycle();
        @(posedge clk);
        advance_model();
        respond_bus();
        id   <= id_drv;
        exec <= exec_drv;
        @(negedge clk);
        if_valid_seen = if_valid;
        check_outputs();
        cycle_cnt++;
    endtask

    function automatic addr_t rand_target();
        addr_t t;
        t      = $urandom();
        t[1:0] = 2'b00;
        return t;
    endfunction

    task automatic set_decode(input id_op_e op, input logic stall);
        id_drv.op        = op;
        id_drv.mem_stall = stall;
        id_drv.next_pc   = rand_target();
    endtask

    task automatic run_jalr();
        test_name = "jalr";
        set_decode(OP_JALR, 1'b0);
        step_cycle();
        set_decode(OP_NONE, 1'b0);  // Target arrives one cycle late.
        step_cycle();
    endtask

    task automatic run_muldiv(input id_op_e op);
        int delay;
        int waited;
        test_name = (op == OP_MUL) ? "mul" : "div";
        delay     = $urandom_range(1, 8);
        waited    = 0;
        exec_drv  = '0;
        set_decode(op, $urandom_range(0, 3) == 0);
        while (exec_drv == '0 && waited < md_timeout) begin
            if (waited == delay) begin
                exec_drv.mul_done = (op == OP_MUL);
                exec_drv.div_done = (op == OP_DIV);
            end
            step_cycle();
            waited++;
        end
        if (exec_drv == '0) begin
            $display("Timeout in %s: done strobe was never sent", test_name);
            timeout_cnt++;
        end
        exec_drv = '0;
        set_decode(OP_NONE, 1'b0);
        waited = 0;
        while (ref_md_st != MD_RETIRE && waited < md_timeout) begin
            step_cycle();
            waited++;
        end
        if (ref_md_st != MD_RETIRE) begin
            $display("Timeout in %s: retire phase never reached", test_name);
            timeout_cnt++;
        end
        step_cycle();  // Retire step, tracker back to idle.
    endtask

    task automatic run_random();
        int pick;
        int len;
        while (cycle_cnt < run_cycles) begin
            pick = $urandom_range(0, 9);
            len  = $urandom_range(1, 3);
            case (pick)
                4: begin
                    test_name = "mem_stall";
                    if ($urandom_range(0, 1) == 1) begin
                        set_decode(OP_REDIRECT, 1'b1);
                    end else begin
                        set_decode(OP_NONE, 1'b1);
                    end
                    repeat (len) step_cycle();
                end
                5: begin
                    test_name = "redirect";
                    set_decode(OP_REDIRECT, 1'b0);
                    step_cycle();
                end
                6: run_jalr();
                7: run_muldiv(OP_MUL);
                8: run_muldiv(OP_DIV);
                default: begin
                    test_name = "plain_fetch";
                    set_decode(OP_NONE, 1'b0);
                    repeat (len) step_cycle();
                end
            endcase
        end
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin
        void'($urandom(32'h895a));
        rst_n         <= 1'b0;
        id            <= '0;
        exec          <= '0;
        bus           <= '0;
        id_drv        = '0;
        exec_drv      = '0;
        ref_bus_st    = BUS_IDLE;
        ref_md_st     = MD_IDLE;
        ref_pc        = tb_reset_pc;
        ref_jalr_d    = 1'b0;
        ref_if_valid  = 1'b0;
        ref_fetch_en  = 1'b0;
        rsp_busy      = 1'b0;
        rsp_hold      = 1'b0;
        rsp_cnt       = 0;
        if_valid_seen = 1'b0;
        cycle_cnt     = 0;
        n_checks      = 0;
        err_cnt       = 0;
        timeout_cnt   = 0;
        chk_fails     = 0;
        test_name     = "reset";
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_outputs();
        @(posedge clk);
        rst_n <= 1'b1;  // Third reset edge.
        test_name = "release";
        step_cycle();
        run_random();
        chk_fails = fetch_ctrl_top_inst.fetch_ctrl_chk_inst.fail_cnt;
        $display("Checks: %0d, mismatches: %0d, timeouts: %0d, assertion failures: %0d",
                 n_checks, err_cnt, timeout_cnt, chk_fails);
        if (err_cnt == 0 && timeout_cnt == 0 && chk_fails == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
core_pkg.sv
fetch_pkg.sv
fetch_bus_track.sv
muldiv_track.sv
pc_update.sv
fetch_ctrl_top.sv
fetch_ctrl_chk.sv
fetch_ctrl_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the fetch control testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module fetch_ctrl_tb \
    -f tb.f \
    -o sim_fetch_ctrl

./obj_dir/sim_fetch_ctrl +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -q "Done: no errors" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
